//--- pePkg.sv
package pePkg;

  ////////////////////
  // data widths
  ////////////////////

  // one feature element
  localparam int DATA_WIDTH = 8;

  ////////////////////
  // layer commands
  ////////////////////

  // any other command byte leaves the FSM idle
  localparam logic [DATA_WIDTH-1:0] LAYER_MAX_POOL = DATA_WIDTH'(2);
  localparam logic [DATA_WIDTH-1:0] LAYER_RELU = DATA_WIDTH'(3);

  // pool header order is C P Q R S xStride yStride
  localparam int POOL_HEADER_LENGTH = 7;

  // relu header order is P Q C
  localparam int RELU_HEADER_LENGTH = 3;

  ////////////////////
  // layer selection
  ////////////////////

  // relu runs on the pool datapath with a 1x1 window
  typedef enum logic {
    kindPool,
    kindRelu
  } layerKind;

endpackage

//--- featureMemIf.sv
interface featureMemIf #(
  parameter int BUFFER_DEPTH = 256
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);

  // write port, takes effect at the clock edge
  logic writeEnable;
  logic [ADDR_WIDTH-1:0] writeAddress;
  logic signed [pePkg::DATA_WIDTH-1:0] writeData;

  // read port, data one cycle after the address
  logic [ADDR_WIDTH-1:0] readAddress;
  logic signed [pePkg::DATA_WIDTH-1:0] readData;

  modport writer (
    output writeEnable,
    output writeAddress,
    output writeData
  );

  modport reader (
    output readAddress,
    input readData
  );

  modport memory (
    input writeEnable,
    input writeAddress,
    input writeData,
    input readAddress,
    output readData
  );

endinterface

//--- featureBuffer.sv
module featureBuffer #(
  parameter int BUFFER_DEPTH = 256
) (
  input logic clock,
  featureMemIf.memory memory
);

  // one signed byte per feature element
  logic signed [pePkg::DATA_WIDTH-1:0] storage [BUFFER_DEPTH];

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clock) begin
    if (memory.writeEnable) begin
      storage[memory.writeAddress] <= memory.writeData;
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // registered read so the store maps onto block RAM
  always_ff @(posedge clock) begin
    memory.readData <= storage[memory.readAddress];
  end

endmodule

//--- layerControl.sv
module layerControl #(
  parameter int BUFFER_DEPTH = 256
) (
  input logic clock,
  input logic reset,
  input logic [pePkg::DATA_WIDTH-1:0] dataIn,
  input logic isNewData,
  featureMemIf.writer inputStore,
  output logic engineStart,
  output pePkg::layerKind kind,
  output logic [pePkg::DATA_WIDTH-1:0] C,
  output logic [pePkg::DATA_WIDTH-1:0] P,
  output logic [pePkg::DATA_WIDTH-1:0] Q,
  output logic [pePkg::DATA_WIDTH-1:0] R,
  output logic [pePkg::DATA_WIDTH-1:0] S,
  output logic [pePkg::DATA_WIDTH-1:0] xStride,
  output logic [pePkg::DATA_WIDTH-1:0] yStride,
  input logic engineDone,
  output logic transmitStart,
  output logic [$clog2(BUFFER_DEPTH)-1:0] outputCount,
  input logic transmitDone
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int COUNT_WIDTH = ADDR_WIDTH + 1;
  localparam logic [pePkg::DATA_WIDTH-1:0] UNIT_SIZE = 1;

  typedef enum logic [2:0] {
    stateIdle,
    stateHeader,
    stateLoadInputs,
    stateCompute,
    stateTransmit
  } controlState;

  controlState state;
  logic lastNewData;
  logic newByte;
  logic [2:0] headerIndex;
  logic lastHeaderByte;
  logic [ADDR_WIDTH-1:0] loadIndex;
  logic [COUNT_WIDTH-1:0] widthIn;
  logic [COUNT_WIDTH-1:0] heightIn;
  logic [COUNT_WIDTH-1:0] inputCount;

  // a level change on isNewData marks a fresh byte
  assign newByte = isNewData != lastNewData;
  assign lastHeaderByte = (kind == pePkg::kindPool) ?
                          (headerIndex == 3'(pePkg::POOL_HEADER_LENGTH - 1)) :
                          (headerIndex == 3'(pePkg::RELU_HEADER_LENGTH - 1));

  // input map size from the captured header
  assign widthIn = COUNT_WIDTH'((P - UNIT_SIZE) * xStride + R);
  assign heightIn = COUNT_WIDTH'((Q - UNIT_SIZE) * yStride + S);
  assign inputCount = COUNT_WIDTH'(heightIn * widthIn * C);
  assign outputCount = ADDR_WIDTH'(P * Q * C);

  // input bytes go to the store in the cycle they are accepted
  assign inputStore.writeEnable = (state == stateLoadInputs) && newByte;
  assign inputStore.writeAddress = loadIndex;
  assign inputStore.writeData = dataIn;

  ////////////////////
  // layer FSM
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= stateIdle;
      lastNewData <= 1'b0;
      headerIndex <= '0;
      loadIndex <= '0;
      engineStart <= 1'b0;
      transmitStart <= 1'b0;
      kind <= pePkg::kindPool;
    end else begin
      engineStart <= 1'b0;
      transmitStart <= 1'b0;
      case (state)
        stateIdle: begin
          if (newByte) begin
            lastNewData <= isNewData;
            headerIndex <= '0;
            if (dataIn == pePkg::LAYER_MAX_POOL) begin
              kind <= pePkg::kindPool;
              state <= stateHeader;
            end else if (dataIn == pePkg::LAYER_RELU) begin
              kind <= pePkg::kindRelu;
              state <= stateHeader;
            end
          end
        end
        stateHeader: begin
          if (newByte) begin
            lastNewData <= isNewData;
            headerIndex <= headerIndex + 1'b1;
            loadIndex <= '0;
            if (lastHeaderByte) begin
              state <= stateLoadInputs;
            end
          end
        end
        stateLoadInputs: begin
          if (newByte) begin
            lastNewData <= isNewData;
            loadIndex <= loadIndex + 1'b1;
            if (COUNT_WIDTH'(loadIndex) == inputCount - COUNT_WIDTH'(1)) begin
              state <= stateCompute;
              engineStart <= 1'b1;
            end
          end
        end
        stateCompute: begin
          if (engineDone) begin
            state <= stateTransmit;
            transmitStart <= 1'b1;
          end
        end
        stateTransmit: begin
          if (transmitDone) begin
            state <= stateIdle;
          end
        end
        default: begin
          state <= stateIdle;
        end
      endcase
    end
  end

  ////////////////////
  // header capture
  ////////////////////

  always_ff @(posedge clock) begin
    if (state == stateIdle && newByte && dataIn == pePkg::LAYER_RELU) begin
      // relu is a unit window with unit stride
      R <= UNIT_SIZE;
      S <= UNIT_SIZE;
      xStride <= UNIT_SIZE;
      yStride <= UNIT_SIZE;
    end else if (state == stateHeader && newByte) begin
      if (kind == pePkg::kindPool) begin
        case (headerIndex)
          3'd0: C <= dataIn;
          3'd1: P <= dataIn;
          3'd2: Q <= dataIn;
          3'd3: R <= dataIn;
          3'd4: S <= dataIn;
          3'd5: xStride <= dataIn;
          default: yStride <= dataIn;
        endcase
      end else begin
        case (headerIndex)
          3'd0: P <= dataIn;
          3'd1: Q <= dataIn;
          default: C <= dataIn;
        endcase
      end
    end
  end

endmodule

//--- featureEngine.sv
module featureEngine #(
  parameter int BUFFER_DEPTH = 256
) (
  input logic clock,
  input logic reset,
  input logic start,
  input pePkg::layerKind kind,
  input logic [pePkg::DATA_WIDTH-1:0] C,
  input logic [pePkg::DATA_WIDTH-1:0] P,
  input logic [pePkg::DATA_WIDTH-1:0] Q,
  input logic [pePkg::DATA_WIDTH-1:0] R,
  input logic [pePkg::DATA_WIDTH-1:0] S,
  input logic [pePkg::DATA_WIDTH-1:0] xStride,
  input logic [pePkg::DATA_WIDTH-1:0] yStride,
  featureMemIf.reader inputStore,
  featureMemIf.writer resultStore,
  output logic done
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int DW = pePkg::DATA_WIDTH;
  localparam logic [DW-1:0] UNIT_SIZE = 1;
  localparam logic signed [DW-1:0] MOST_NEGATIVE = {1'b1, {(DW - 1){1'b0}}};

  // scan counters, s runs fastest and c slowest
  logic [DW-1:0] c;
  logic [DW-1:0] p;
  logic [DW-1:0] q;
  logic [DW-1:0] r;
  logic [DW-1:0] s;
  logic running;
  logic windowEnd;
  logic scanEnd;
  logic [ADDR_WIDTH-1:0] heightIn;
  logic [ADDR_WIDTH-1:0] widthIn;
  logic [ADDR_WIDTH-1:0] outputAddress;

  // read return stage
  logic issuedD1;
  logic firstD1;
  logic lastD1;
  logic finalD1;
  logic [ADDR_WIDTH-1:0] outAddrD1;
  logic signed [DW-1:0] windowBase;
  logic signed [DW-1:0] maxNext;
  logic signed [DW-1:0] reluData;
  logic signed [DW-1:0] runningMax;

  // pool write stage
  logic poolWriteValid;
  logic poolWriteFinal;
  logic [ADDR_WIDTH-1:0] poolWriteAddress;
  logic signed [DW-1:0] poolWriteData;
  logic finalWrite;

  assign heightIn = ADDR_WIDTH'((Q - UNIT_SIZE) * yStride + S);
  assign widthIn = ADDR_WIDTH'((P - UNIT_SIZE) * xStride + R);

  assign inputStore.readAddress = ADDR_WIDTH'((q * xStride + s) +
                                              (p * yStride + r) * heightIn +
                                              c * heightIn * widthIn);
  assign outputAddress = ADDR_WIDTH'(q + p * Q + c * Q * P);

  assign windowEnd = (s == S - UNIT_SIZE) && (r == R - UNIT_SIZE);
  assign scanEnd = windowEnd && (q == Q - UNIT_SIZE) && (p == P - UNIT_SIZE) &&
                   (c == C - UNIT_SIZE);

  ////////////////////
  // window scan
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      running <= 1'b0;
      issuedD1 <= 1'b0;
    end else begin
      issuedD1 <= running;
      if (start) begin
        running <= 1'b1;
      end else if (running && scanEnd) begin
        running <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      c <= '0;
      p <= '0;
      q <= '0;
      r <= '0;
      s <= '0;
    end else if (running) begin
      if (s != S - UNIT_SIZE) begin
        s <= s + UNIT_SIZE;
      end else begin
        s <= '0;
        if (r != R - UNIT_SIZE) begin
          r <= r + UNIT_SIZE;
        end else begin
          r <= '0;
          if (q != Q - UNIT_SIZE) begin
            q <= q + UNIT_SIZE;
          end else begin
            q <= '0;
            if (p != P - UNIT_SIZE) begin
              p <= p + UNIT_SIZE;
            end else begin
              p <= '0;
              c <= c + UNIT_SIZE;
            end
          end
        end
      end
    end
  end

  // tags travel with each read until its data returns
  always_ff @(posedge clock) begin
    firstD1 <= (s == '0) && (r == '0);
    lastD1 <= windowEnd;
    finalD1 <= scanEnd;
    outAddrD1 <= outputAddress;
  end

  ////////////////////
  // max and relu
  ////////////////////

  assign windowBase = firstD1 ? MOST_NEGATIVE : runningMax;
  assign maxNext = (inputStore.readData > windowBase) ? inputStore.readData : windowBase;
  assign reluData = inputStore.readData[DW-1] ? '0 : inputStore.readData;

  always_ff @(posedge clock) begin
    if (issuedD1) begin
      runningMax <= maxNext;
    end
    poolWriteAddress <= outAddrD1;
    poolWriteData <= maxNext;
    poolWriteFinal <= finalD1;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      poolWriteValid <= 1'b0;
      done <= 1'b0;
    end else begin
      poolWriteValid <= issuedD1 && lastD1;
      done <= finalWrite;
    end
  end

  // relu writes straight from the read data, pool one cycle later
  assign resultStore.writeEnable = (kind == pePkg::kindRelu) ? issuedD1 : poolWriteValid;
  assign resultStore.writeAddress = (kind == pePkg::kindRelu) ? outAddrD1 : poolWriteAddress;
  assign resultStore.writeData = (kind == pePkg::kindRelu) ? reluData : poolWriteData;
  assign finalWrite = (kind == pePkg::kindRelu) ? (issuedD1 && finalD1) :
                                                  (poolWriteValid && poolWriteFinal);

endmodule

//--- byteTransmitter.sv
module byteTransmitter #(
  parameter int BUFFER_DEPTH = 256,
  parameter int GAP_CYCLES = 11
) (
  input logic clock,
  input logic reset,
  input logic start,
  input logic [$clog2(BUFFER_DEPTH)-1:0] outputCount,
  featureMemIf.reader resultStore,
  input logic isBusy,
  output logic [pePkg::DATA_WIDTH-1:0] dataOut,
  output logic doTransmit,
  output logic done
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int GAP_WIDTH = $clog2(GAP_CYCLES + 1);

  logic active;
  logic sendNow;
  logic sendingLast;
  logic [ADDR_WIDTH-1:0] sendIndex;
  logic [GAP_WIDTH-1:0] gapCount;

  // next byte is fetched while the gap runs
  assign resultStore.readAddress = sendIndex;
  assign sendNow = active && !isBusy && (gapCount == GAP_WIDTH'(GAP_CYCLES - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      active <= 1'b0;
      sendingLast <= 1'b0;
      sendIndex <= '0;
      gapCount <= '0;
      dataOut <= '0;
      doTransmit <= 1'b0;
      done <= 1'b0;
    end else begin
      doTransmit <= sendNow;
      done <= sendingLast;
      sendingLast <= sendNow && (sendIndex == outputCount - 1'b1);
      if (start) begin
        active <= 1'b1;
        sendIndex <= '0;
        gapCount <= '0;
      end else if (sendNow) begin
        dataOut <= resultStore.readData;
        gapCount <= '0;
        sendIndex <= sendIndex + 1'b1;
        if (sendIndex == outputCount - 1'b1) begin
          active <= 1'b0;
        end
      end else if (active && !isBusy) begin
        // busy cycles pause the gap count
        gapCount <= gapCount + 1'b1;
      end
    end
  end

endmodule

//--- dnnProcessingElement.sv
module dnnProcessingElement #(
  parameter int BUFFER_DEPTH = 256,
  parameter int GAP_CYCLES = 11
) (
  input logic clock,
  input logic reset,
  input logic [pePkg::DATA_WIDTH-1:0] dataIn,
  input logic isNewData,
  input logic isBusy,
  output logic [pePkg::DATA_WIDTH-1:0] dataOut,
  output logic doTransmit
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);

  logic engineStart;
  logic engineDone;
  logic transmitStart;
  logic transmitDone;
  pePkg::layerKind kind;
  logic [ADDR_WIDTH-1:0] outputCount;

  // layer sizes from the header
  logic [pePkg::DATA_WIDTH-1:0] C;
  logic [pePkg::DATA_WIDTH-1:0] P;
  logic [pePkg::DATA_WIDTH-1:0] Q;
  logic [pePkg::DATA_WIDTH-1:0] R;
  logic [pePkg::DATA_WIDTH-1:0] S;
  logic [pePkg::DATA_WIDTH-1:0] xStride;
  logic [pePkg::DATA_WIDTH-1:0] yStride;

  ////////////////////
  // feature stores
  ////////////////////

  featureMemIf #(.BUFFER_DEPTH(BUFFER_DEPTH)) inputStore ();
  featureMemIf #(.BUFFER_DEPTH(BUFFER_DEPTH)) resultStore ();

  featureBuffer #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) u_inputBuffer (
    .clock(clock),
    .memory(inputStore)
  );

  featureBuffer #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) u_resultBuffer (
    .clock(clock),
    .memory(resultStore)
  );

  ////////////////////
  // layer pipeline
  ////////////////////

  layerControl #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) u_layerControl (
    .clock(clock),
    .reset(reset),
    .dataIn(dataIn),
    .isNewData(isNewData),
    .inputStore(inputStore),
    .engineStart(engineStart),
    .kind(kind),
    .C(C),
    .P(P),
    .Q(Q),
    .R(R),
    .S(S),
    .xStride(xStride),
    .yStride(yStride),
    .engineDone(engineDone),
    .transmitStart(transmitStart),
    .outputCount(outputCount),
    .transmitDone(transmitDone)
  );

  featureEngine #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) u_featureEngine (
    .clock(clock),
    .reset(reset),
    .start(engineStart),
    .kind(kind),
    .C(C),
    .P(P),
    .Q(Q),
    .R(R),
    .S(S),
    .xStride(xStride),
    .yStride(yStride),
    .inputStore(inputStore),
    .resultStore(resultStore),
    .done(engineDone)
  );

  byteTransmitter #(
    .BUFFER_DEPTH(BUFFER_DEPTH),
    .GAP_CYCLES(GAP_CYCLES)
  ) u_byteTransmitter (
    .clock(clock),
    .reset(reset),
    .start(transmitStart),
    .outputCount(outputCount),
    .resultStore(resultStore),
    .isBusy(isBusy),
    .dataOut(dataOut),
    .doTransmit(doTransmit),
    .done(transmitDone)
  );

endmodule

//--- dnnProcessingElement_asserts.sv
module dnnProcessingElement_asserts (
  input logic clock,
  input logic reset,
  input logic isBusy,
  input logic doTransmit
);

  ////////////////////
  // output strobe
  ////////////////////

  // one cycle per byte
  singleCycleStrobe: assert property (@(posedge clock) disable iff (reset)
    doTransmit |=> !doTransmit)
    else $error("doTransmit high for two cycles in a row");

  // registered strobe, so checked one edge after reset is seen
  quietInReset: assert property (@(posedge clock) $past(reset) |-> !doTransmit)
    else $error("doTransmit high during reset");

  // a busy receiver holds the strobe off
  idleBeforeStrobe: assert property (@(posedge clock) disable iff (reset)
    doTransmit |-> !$past(isBusy))
    else $error("doTransmit after a busy cycle");

endmodule

bind dnnProcessingElement dnnProcessingElement_asserts u_asserts (
  .clock(clock),
  .reset(reset),
  .isBusy(isBusy),
  .doTransmit(doTransmit)
);

//--- peTb.sv
module peTb;

  localparam int BUFFER_DEPTH = 256;
  localparam int GAP_CYCLES = 11;
  localparam int CLOCK_PERIOD = 20;
  localparam int RESET_CYCLES = 10;
  localparam int BYTE_SPACING = 4;
  // worst-case busy and compute cycles per vector byte
  localparam int BUSY_ALLOWANCE = 24;

  logic clock;
  logic reset;
  logic [pePkg::DATA_WIDTH-1:0] dataIn;
  logic isNewData;
  logic isBusy = 1'b0;
  logic [pePkg::DATA_WIDTH-1:0] dataOut;
  logic doTransmit;

  // all cases back to back with one length entry per case
  logic [pePkg::DATA_WIDTH-1:0] streamBytes [$];
  logic [pePkg::DATA_WIDTH-1:0] expectedBytes [$];
  int streamLengths [$];
  int expectedLengths [$];

  // output bytes still owed by the DUT
  logic [pePkg::DATA_WIDTH-1:0] pending [$];
  logic [pePkg::DATA_WIDTH-1:0] nextExpected;
  int checkedCount = 0;
  int seed = 14;
  bit vectorsLoaded = 1'b0;
  longint watchdogLimit;

  dnnProcessingElement #(
    .BUFFER_DEPTH(BUFFER_DEPTH),
    .GAP_CYCLES(GAP_CYCLES)
  ) u_dnnProcessingElement (
    .clock(clock),
    .reset(reset),
    .dataIn(dataIn),
    .isNewData(isNewData),
    .isBusy(isBusy),
    .dataOut(dataOut),
    .doTransmit(doTransmit)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  task automatic stopRun();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compareByte(input logic [pePkg::DATA_WIDTH-1:0] actual,
                             input logic [pePkg::DATA_WIDTH-1:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at time %0t: %s is 0x%02h, expected 0x%02h", $time, what, actual,
               expected);
      stopRun();
    end
  endtask

  ////////////////////
  // vector file
  ////////////////////

  task automatic loadVectors();
    int fd;
    int code;
    int count;
    int i;
    logic [8*16-1:0] word;
    logic [8*256-1:0] restOfLine;
    logic [pePkg::DATA_WIDTH-1:0] value;
    fd = $fopen("peVectors.txt", "r");
    if (fd == 0) begin
      $display("could not open peVectors.txt");
      stopRun();
    end
    word = '0;
    code = $fscanf(fd, "%s", word);
    while (code == 1) begin
      if (word == "#") begin
        code = $fgets(restOfLine, fd);
      end else if (word == "in" || word == "out") begin
        code = $fscanf(fd, "%d", count);
        for (i = 0; i < count; i++) begin
          code = $fscanf(fd, "%h", value);
          if (code != 1) begin
            $display("peVectors.txt ends in the middle of a byte list");
            stopRun();
          end else if (word == "in") begin
            streamBytes.push_back(value);
          end else begin
            expectedBytes.push_back(value);
          end
        end
        if (word == "in") begin
          streamLengths.push_back(count);
        end else begin
          expectedLengths.push_back(count);
        end
      end else begin
        $display("peVectors.txt holds a line that is neither in nor out");
        stopRun();
      end
      word = '0;
      code = $fscanf(fd, "%s", word);
    end
    $fclose(fd);
    if (streamLengths.size() != expectedLengths.size()) begin
      $display("peVectors.txt has an in line without its out line");
      stopRun();
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  // a level change on isNewData marks the byte
  task automatic sendByte(input logic [pePkg::DATA_WIDTH-1:0] value);
    @(posedge clock);
    dataIn <= value;
    isNewData <= ~isNewData;
    repeat (BYTE_SPACING - 1) @(posedge clock);
  endtask

  task automatic runCase(input int caseIndex, input int streamStart, input int expectStart);
    int i;
    for (i = 0; i < streamLengths[caseIndex]; i++) begin
      sendByte(streamBytes[streamStart + i]);
    end
    // expected bytes armed once the whole stream is in
    for (i = 0; i < expectedLengths[caseIndex]; i++) begin
      pending.push_back(expectedBytes[expectStart + i]);
    end
    while (pending.size() != 0) begin
      @(posedge clock);
    end
  endtask

  initial begin
    int caseIndex;
    int streamStart;
    int expectStart;
    reset = 1'b1;
    dataIn = '0;
    isNewData = 1'b0;
    loadVectors();
    watchdogLimit = longint'(RESET_CYCLES + (streamBytes.size() + expectedBytes.size()) *
                    (GAP_CYCLES + BUSY_ALLOWANCE)) * CLOCK_PERIOD;
    vectorsLoaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    streamStart = 0;
    expectStart = 0;
    for (caseIndex = 0; caseIndex < streamLengths.size(); caseIndex++) begin
      runCase(caseIndex, streamStart, expectStart);
      streamStart += streamLengths[caseIndex];
      expectStart += expectedLengths[caseIndex];
    end
    // room for a late extra strobe to show up
    repeat (GAP_CYCLES * 4) @(posedge clock);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // random back-pressure on the output side
  always @(posedge clock) begin
    if (reset) begin
      isBusy <= 1'b0;
    end else begin
      isBusy <= (($random(seed) & 3) == 0);
    end
  end

  ////////////////////
  // output monitor
  ////////////////////

  always @(negedge clock) begin
    if (!reset && doTransmit) begin
      if (pending.size() == 0) begin
        $display("doTransmit at time %0t while no output byte was expected", $time);
        stopRun();
      end else begin
        nextExpected = pending.pop_front();
        compareByte(dataOut, nextExpected, $sformatf("output byte %0d", checkedCount));
        checkedCount++;
      end
    end
  end

  initial begin
    wait (vectorsLoaded);
    #(watchdogLimit);
    $display("the run timed out at %0t with %0d output bytes never sent", $time,
             pending.size());
    stopRun();
  end

endmodule

//--- peVectors.txt
# in, byte count in decimal, then command, header and input map bytes in hex
# out, byte count in decimal, then the expected dataOut bytes in hex in send order
# pool with 2x2 window and stride 2 over two 4x4 channels
in 40 02 02 02 02 02 02 02 02 01 05 fe 03 07 80 04 ff f0 f1 10 20 f2 f3 0a 7f
      80 80 81 82 80 80 83 84 00 ff 64 9c fe fd 9c 63
out 8 07 04 f3 7f 80 84 00 64
# pool with overlapping 3x3 windows and stride 1 over one 4x4 channel
in 24 02 01 02 02 03 03 01 01 10 f0 20 01 f5 30 f6 02 03 04 05 60 50 80 06 07
out 4 30 60 50 60
# relu with P 3, Q 2, C 2
in 16 03 03 02 02 05 fb 00 7f 80 ff 01 40 c0 12 ee 33
out 12 05 00 00 7f 00 00 01 40 00 12 00 33
# unknown commands 1, 4 and 9, then relu with P 2, Q 2, C 1
in 11 01 04 09 03 02 02 01 9c 64 ff 00
out 4 00 64 00 00
# back to back, a single window pool and then relu over three channels
in 12 02 01 01 01 02 02 02 02 85 86 87 88
out 1 88
in 10 03 02 01 03 81 7e 00 d0 2a ff
out 6 00 7e 00 00 2a 00

//--- list.f
pePkg.sv
featureMemIf.sv
featureBuffer.sv
layerControl.sv
featureEngine.sv
byteTransmitter.sv
dnnProcessingElement.sv
dnnProcessingElement_asserts.sv
peTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module peTb -f list.f -o peSim || exit 1
simOutput=$(./obj_dir/peSim 2>&1)
echo "$simOutput"
echo "$simOutput" | grep -qx "ALL CHECKS PASSED" && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
